/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // processor word address, split as tag | set | word offset
    localparam int ADDR_W = 25;
    localparam int OFS_W  = 2;   // word within a line
    localparam int SET_W  = 4;   // 16 sets
    localparam int TAG_W  = ADDR_W - SET_W - OFS_W;

    // memory side works on whole lines
    localparam int LINE_ADDR_W = 23;

    // associativity
    localparam int WAYS  = 8;
    localparam int WAY_W = 3;

    // data widths
    localparam int WORD_W = 32;
    localparam int LINE_W = 128; // four words per line

    // tree pseudo-LRU, WAYS-1 bits per set
    localparam int PLRU_W = 7;

    // request sequencing in the controller
    typedef enum logic [2:0] {
        IDLE,   // waiting for a processor request
        COMP,   // tag compare on the registered way outputs
        HIT,    // write hit, merge into the hit way
        FETCH1, // line read command on the memory port
        FETCH2, // waiting for the line to return
        FETCH3, // write miss, merge after the fill
        WB1,    // load the dirty victim into the write registers
        WB2     // line write command on the memory port
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [cache_pkg::SET_W-1:0] i_set,
    input  wire logic [cache_pkg::TAG_W-1:0] i_tag,
    input  wire logic                        i_we,
    input  wire logic                        i_fill,
    input  wire logic [3:0]                  i_word_en,
    input  wire logic [3:0]                  i_byte_en,
    input  wire logic [cache_pkg::LINE_W-1:0] i_wdata,
    output logic                             o_hit,
    output logic                             o_valid,
    output logic                             o_dirty,
    output logic      [cache_pkg::TAG_W-1:0] o_tag,
    output logic      [cache_pkg::LINE_W-1:0] o_line
);

    import cache_pkg::*;

    logic [TAG_W-1:0]    tag_mem  [2**SET_W];
    logic [LINE_W-1:0]   data_mem [2**SET_W];
    logic [2**SET_W-1:0] valid_bits;
    logic [2**SET_W-1:0] dirty_bits;

    logic [TAG_W-1:0]  tag_q;
    logic [LINE_W-1:0] line_q;
    logic              valid_q;
    logic              dirty_q;

    // tag and data storage, registered read at i_set
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_set]  <= i_tag;
            data_mem[i_set] <= i_wdata;
        end
        // byte writes land after the fill so they win on overlap
        if (i_we) begin
            for (int w = 0; w < 4; w++) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_word_en[w] && i_byte_en[b]) begin
                        data_mem[i_set][w*WORD_W + b*8 +: 8] <= i_wdata[w*WORD_W + b*8 +: 8];
                    end
                end
            end
        end
        tag_q  <= tag_mem[i_set];
        line_q <= data_mem[i_set];
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            if (i_fill) begin
                valid_bits[i_set] <= 1'b1;
                dirty_bits[i_set] <= 1'b0; // fresh copy of memory
            end
            if (i_we) begin
                dirty_bits[i_set] <= 1'b1;
            end
            valid_q <= valid_bits[i_set];
            dirty_q <= dirty_bits[i_set];
        end
    end

    assign o_hit   = valid_q && (tag_q == i_tag);
    assign o_valid = valid_q;
    assign o_dirty = dirty_q;
    assign o_tag   = tag_q;
    assign o_line  = line_q;

endmodule

`default_nettype wire

/* source/plru_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [cache_pkg::SET_W-1:0] i_set,
    input  wire logic                        i_access,
    input  wire logic [cache_pkg::WAY_W-1:0] i_way,
    output logic      [cache_pkg::WAY_W-1:0] o_victim
);

    import cache_pkg::*;

    logic [PLRU_W-1:0] plru_q [2**SET_W];
    logic [PLRU_W-1:0] cur;
    logic [PLRU_W-1:0] nxt;
    logic              v_hi;
    logic              v_mid;
    logic              v_lo;

    assign cur = plru_q[i_set];

    // walk the tree: bit 6 root, bits 5/4 middle, bits 3..0 leaf pairs 1/0 .. 7/6
    always_comb begin
        v_hi  = cur[6];
        v_mid = v_hi ? cur[4] : cur[5];
        case ({v_hi, v_mid})
            2'b11:   v_lo = cur[0];
            2'b10:   v_lo = cur[1];
            2'b01:   v_lo = cur[2];
            default: v_lo = cur[3];
        endcase
        o_victim = {v_hi, v_mid, v_lo};
    end

    // point every node on the accessed path away from it
    always_comb begin
        nxt    = cur;
        nxt[6] = ~i_way[2];
        if (i_way[2]) begin
            nxt[4] = ~i_way[1];
            if (i_way[1]) begin
                nxt[0] = ~i_way[0];
            end else begin
                nxt[1] = ~i_way[0];
            end
        end else begin
            nxt[5] = ~i_way[1];
            if (i_way[1]) begin
                nxt[2] = ~i_way[0];
            end else begin
                nxt[3] = ~i_way[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**SET_W; s++) begin
                plru_q[s] <= '0;
            end
        end else if (i_access) begin
            plru_q[i_set] <= nxt;
        end
    end

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire logic                               clk,
    input  wire logic                               rst,
    // processor port
    input  wire logic [cache_pkg::ADDR_W-1:0]       i_p_addr,
    input  wire logic                               i_p_read,
    input  wire logic                               i_p_write,
    input  wire logic [cache_pkg::WORD_W-1:0]       i_p_writedata,
    input  wire logic [3:0]                         i_p_byte_en,
    output logic                                    o_p_waitrequest,
    output logic      [cache_pkg::WORD_W-1:0]       o_p_readdata,
    output logic                                    o_p_readdata_valid,
    // memory port
    output logic                                    o_m_read,
    output logic                                    o_m_write,
    output logic      [cache_pkg::LINE_ADDR_W-1:0]  o_m_addr,
    output logic      [cache_pkg::LINE_W-1:0]       o_m_writedata,
    output logic      [3:0]                         o_m_byte_en,
    input  wire logic                               i_m_waitrequest,
    input  wire logic [cache_pkg::LINE_W-1:0]       i_m_readdata,
    input  wire logic                               i_m_readdata_valid,
    // way control
    output logic      [cache_pkg::SET_W-1:0]        o_set,
    output logic      [cache_pkg::TAG_W-1:0]        o_tag,
    output logic      [cache_pkg::WAYS-1:0]         o_way_we,
    output logic      [cache_pkg::WAYS-1:0]         o_way_fill,
    output logic      [3:0]                         o_word_en,
    output logic      [3:0]                         o_byte_en,
    output logic      [cache_pkg::LINE_W-1:0]       o_wdata,
    input  wire logic [cache_pkg::WAYS-1:0]         i_hit,
    input  wire logic [cache_pkg::WAYS-1:0]         i_valid,
    input  wire logic [cache_pkg::WAYS-1:0]         i_dirty,
    input  wire logic [cache_pkg::WAYS*cache_pkg::TAG_W-1:0]  i_tag_all,
    input  wire logic [cache_pkg::WAYS*cache_pkg::LINE_W-1:0] i_line_all,
    // replacement
    output logic                                    o_plru_access,
    output logic      [cache_pkg::WAY_W-1:0]        o_plru_way,
    input  wire logic [cache_pkg::WAY_W-1:0]        i_victim
);

    import cache_pkg::*;

    ctrl_state_t state;

    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] wdata_q;
    logic [3:0]        be_q;
    logic              is_write_q;
    logic [WAY_W-1:0]  way_q;  // hit way or allocated way

    logic              hit_any;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  inv_way;
    logic [WAY_W-1:0]  alloc_way;
    logic [WAYS-1:0]   way_onehot;
    logic [LINE_W-1:0] hit_line;
    logic [OFS_W-1:0]  word_idx;

    // lowest numbered hit and lowest numbered free way
    always_comb begin
        hit_way = '0;
        inv_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (i_hit[w]) begin
                hit_way = WAY_W'(w);
            end
            if (!i_valid[w]) begin
                inv_way = WAY_W'(w);
            end
        end
    end

    assign hit_any    = |i_hit;
    assign alloc_way  = (&i_valid) ? i_victim : inv_way;
    assign way_onehot = {{(WAYS-1){1'b0}}, 1'b1} << way_q;
    assign hit_line   = i_line_all[hit_way*LINE_W +: LINE_W];
    assign word_idx   = addr_q[OFS_W-1:0];

    // ways read at the incoming address while idle so COMP sees the set
    assign o_set     = (state == IDLE) ? i_p_addr[OFS_W +: SET_W] : addr_q[OFS_W +: SET_W];
    assign o_tag     = addr_q[ADDR_W-1 -: TAG_W];
    assign o_word_en = 4'b0001 << word_idx;
    assign o_byte_en = be_q;
    assign o_wdata   = (state == FETCH2) ? i_m_readdata : {4{wdata_q}};

    assign o_way_we   = (state == HIT || state == FETCH3) ? way_onehot : '0;
    assign o_way_fill = (state == FETCH2 && i_m_readdata_valid) ? way_onehot : '0;

    assign o_plru_access = (state == COMP); // every compare ends in a hit or an allocation
    assign o_plru_way    = hit_any ? hit_way : alloc_way;

    assign o_p_waitrequest = (state != IDLE);
    assign o_m_byte_en     = 4'b1111;

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    o_p_readdata_valid <= 1'b0;
                    if (i_p_read || i_p_write) begin
                        addr_q     <= i_p_addr;
                        wdata_q    <= i_p_writedata;
                        be_q       <= i_p_byte_en;
                        is_write_q <= !i_p_read; // read wins if both are raised
                        state      <= COMP;
                    end
                end
                COMP: begin
                    if (hit_any) begin
                        way_q <= hit_way;
                        if (is_write_q) begin
                            state <= HIT;
                        end else begin
                            o_p_readdata       <= hit_line[word_idx*WORD_W +: WORD_W];
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end
                    end else begin
                        way_q <= alloc_way;
                        if ((&i_valid) && i_dirty[i_victim]) begin
                            state <= WB1;
                        end else begin
                            o_m_addr <= addr_q[ADDR_W-1:OFS_W];
                            o_m_read <= 1'b1;
                            state    <= FETCH1;
                        end
                    end
                end
                HIT: begin
                    state <= IDLE;
                end
                FETCH1: begin
                    if (!i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                        state    <= FETCH2;
                    end
                end
                FETCH2: begin
                    if (i_m_readdata_valid) begin
                        if (is_write_q) begin
                            state <= FETCH3;
                        end else begin
                            o_p_readdata       <= i_m_readdata[word_idx*WORD_W +: WORD_W];
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end
                    end
                end
                FETCH3: begin
                    state <= IDLE;
                end
                WB1: begin
                    o_m_addr      <= {i_tag_all[way_q*TAG_W +: TAG_W], addr_q[OFS_W +: SET_W]};
                    o_m_writedata <= i_line_all[way_q*LINE_W +: LINE_W];
                    o_m_write     <= 1'b1;
                    state         <= WB2;
                end
                WB2: begin
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        o_m_addr  <= addr_q[ADDR_W-1:OFS_W]; // go on with the fill read
                        o_m_read  <= 1'b1;
                        state     <= FETCH1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [cache_pkg::ADDR_W-1:0]      i_p_addr,
    input  wire logic                              i_p_read,
    input  wire logic                              i_p_write,
    input  wire logic [cache_pkg::WORD_W-1:0]      i_p_writedata,
    input  wire logic [3:0]                        i_p_byte_en,
    output logic                                   o_p_waitrequest,
    output logic      [cache_pkg::WORD_W-1:0]      o_p_readdata,
    output logic                                   o_p_readdata_valid,
    output logic                                   o_m_read,
    output logic                                   o_m_write,
    output logic      [cache_pkg::LINE_ADDR_W-1:0] o_m_addr,
    output logic      [cache_pkg::LINE_W-1:0]      o_m_writedata,
    output logic      [3:0]                        o_m_byte_en,
    input  wire logic                              i_m_waitrequest,
    input  wire logic [cache_pkg::LINE_W-1:0]      i_m_readdata,
    input  wire logic                              i_m_readdata_valid
);

    import cache_pkg::*;

    logic [SET_W-1:0]       set;
    logic [TAG_W-1:0]       tag;
    logic [WAYS-1:0]        way_we;
    logic [WAYS-1:0]        way_fill;
    logic [3:0]             word_en;
    logic [3:0]             byte_en;
    logic [LINE_W-1:0]      wdata;
    logic [WAYS-1:0]        hit;
    logic [WAYS-1:0]        valid;
    logic [WAYS-1:0]        dirty;
    logic [WAYS*TAG_W-1:0]  tag_all;
    logic [WAYS*LINE_W-1:0] line_all;
    logic                   plru_access;
    logic [WAY_W-1:0]       plru_way;
    logic [WAY_W-1:0]       victim;

    cache_ctrl cache_ctrl_i (
        .clk, .rst,
        .i_p_addr, .i_p_read, .i_p_write, .i_p_writedata, .i_p_byte_en,
        .o_p_waitrequest, .o_p_readdata, .o_p_readdata_valid,
        .o_m_read, .o_m_write, .o_m_addr, .o_m_writedata, .o_m_byte_en,
        .i_m_waitrequest, .i_m_readdata, .i_m_readdata_valid,
        .o_set(set), .o_tag(tag), .o_way_we(way_we), .o_way_fill(way_fill),
        .o_word_en(word_en), .o_byte_en(byte_en), .o_wdata(wdata),
        .i_hit(hit), .i_valid(valid), .i_dirty(dirty),
        .i_tag_all(tag_all), .i_line_all(line_all),
        .o_plru_access(plru_access), .o_plru_way(plru_way), .i_victim(victim)
    );

    for (genvar g = 0; g < WAYS; g++) begin : gen_way
        cache_way cache_way_i (
            .clk, .rst,
            .i_set(set), .i_tag(tag),
            .i_we(way_we[g]), .i_fill(way_fill[g]),
            .i_word_en(word_en), .i_byte_en(byte_en), .i_wdata(wdata),
            .o_hit(hit[g]), .o_valid(valid[g]), .o_dirty(dirty[g]),
            .o_tag(tag_all[g*TAG_W +: TAG_W]),
            .o_line(line_all[g*LINE_W +: LINE_W])
        );
    end

    plru_tree plru_tree_i (
        .clk, .rst,
        .i_set(set), .i_access(plru_access), .i_way(plru_way),
        .o_victim(victim)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  wire logic                                clk,
    input  wire logic                                i_read,
    input  wire logic                                i_write,
    input  wire logic [cache_pkg::LINE_ADDR_W-1:0]   i_addr,
    input  wire logic [cache_pkg::LINE_W-1:0]        i_writedata,
    output logic                                     o_waitrequest,
    output logic      [cache_pkg::LINE_W-1:0]        o_readdata,
    output logic                                     o_readdata_valid,
    output int                                       o_rd_count,
    output int                                       o_wr_count,
    output logic      [cache_pkg::LINE_ADDR_W-1:0]   o_rd_addr,
    output logic      [cache_pkg::LINE_ADDR_W-1:0]   o_wr_addr,
    output logic      [cache_pkg::LINE_W-1:0]        o_wr_data,
    output int                                       o_rd_seq,
    output int                                       o_wr_seq
);

    import cache_pkg::*;

    logic [LINE_ADDR_W-1:0] line_addr_q [$]; // lines written so far, newest last
    logic [LINE_W-1:0]      line_data_q [$];
    logic                   busy = 1'b0;
    int                     wait_left = 0;
    int                     seq = 0;      // order of executed commands
    logic                   cmd_write;
    logic [LINE_ADDR_W-1:0] cmd_addr;
    logic [LINE_W-1:0]      cmd_data;

    function automatic logic [LINE_W-1:0] read_line(input logic [LINE_ADDR_W-1:0] a);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*WORD_W +: WORD_W] = {7'b0, a, 2'(w)} ^ PATTERN; // untouched line
        end
        for (int i = 0; i < line_addr_q.size(); i++) begin
            if (line_addr_q[i] == a) begin
                line = line_data_q[i];
            end
        end
        return line;
    endfunction

    initial begin
        o_waitrequest    = 1'b0;
        o_readdata       = '0;
        o_readdata_valid = 1'b0;
        o_rd_count       = 0;
        o_wr_count       = 0;
        o_rd_addr        = '0;
        o_wr_addr        = '0;
        o_wr_data        = '0;
        o_rd_seq         = 0;
        o_wr_seq         = 0;
    end

    always @(negedge clk) begin
        o_readdata_valid <= 1'b0;
        if (busy) begin
            if (wait_left == 0) begin
                // waitrequest was low at the last rising edge, so the command was taken
                busy = 1'b0;
                if (cmd_write) begin
                    line_addr_q.push_back(cmd_addr);
                    line_data_q.push_back(cmd_data);
                    o_wr_count <= o_wr_count + 1;
                    o_wr_addr  <= cmd_addr;
                    o_wr_data  <= cmd_data;
                    o_wr_seq   <= seq;
                end else begin
                    o_readdata       <= read_line(cmd_addr);
                    o_readdata_valid <= 1'b1;
                    o_rd_count       <= o_rd_count + 1;
                    o_rd_addr        <= cmd_addr;
                    o_rd_seq         <= seq;
                end
                seq++;
            end else begin
                wait_left--;
                o_waitrequest <= (wait_left != 0);
            end
        end
        if (!busy && (i_read || i_write)) begin
            busy          = 1'b1;
            cmd_write     = i_write;
            cmd_addr      = i_addr;
            cmd_data      = i_writedata;
            wait_left     = $urandom_range(0, 3);
            o_waitrequest <= (wait_left != 0);
        end
    end

endmodule

`default_nettype wire

/* tests/tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

    import cache_pkg::*;

    localparam logic [WORD_W-1:0] MEM_PATTERN = 32'h5ac3_1e97;
    localparam int                TIMEOUT     = 200;

    logic                   clk;
    logic                   rst;
    logic [ADDR_W-1:0]      p_addr;
    logic                   p_read;
    logic                   p_write;
    logic [WORD_W-1:0]      p_writedata;
    logic [3:0]             p_byte_en;
    logic                   p_waitrequest;
    logic [WORD_W-1:0]      p_readdata;
    logic                   p_readdata_valid;
    logic                   m_read;
    logic                   m_write;
    logic [LINE_ADDR_W-1:0] m_addr;
    logic [LINE_W-1:0]      m_writedata;
    logic [3:0]             m_byte_en;
    logic                   m_waitrequest;
    logic [LINE_W-1:0]      m_readdata;
    logic                   m_readdata_valid;
    int                     rd_count;
    int                     wr_count;
    logic [LINE_ADDR_W-1:0] rd_addr;
    logic [LINE_ADDR_W-1:0] wr_addr;
    logic [LINE_W-1:0]      wr_data;
    int                     rd_seq;
    int                     wr_seq;

    logic                   last_m_read;  // memory command at the previous falling edge
    logic                   last_m_write;
    logic [LINE_ADDR_W-1:0] last_m_addr;
    logic [LINE_W-1:0]      last_m_writedata;

    logic [ADDR_W-1:0] shadow_addr [$]; // processor writes, newest last
    logic [WORD_W-1:0] shadow_data [$];

    always #5 clk = ~clk;

    cache_top cache_top_i (
        .clk, .rst,
        .i_p_addr(p_addr), .i_p_read(p_read), .i_p_write(p_write),
        .i_p_writedata(p_writedata), .i_p_byte_en(p_byte_en),
        .o_p_waitrequest(p_waitrequest), .o_p_readdata(p_readdata),
        .o_p_readdata_valid(p_readdata_valid),
        .o_m_read(m_read), .o_m_write(m_write), .o_m_addr(m_addr),
        .o_m_writedata(m_writedata), .o_m_byte_en(m_byte_en),
        .i_m_waitrequest(m_waitrequest), .i_m_readdata(m_readdata),
        .i_m_readdata_valid(m_readdata_valid)
    );

    mem_model #(.PATTERN(MEM_PATTERN)) mem_model_i (
        .clk, .i_read(m_read), .i_write(m_write), .i_addr(m_addr),
        .i_writedata(m_writedata), .o_waitrequest(m_waitrequest),
        .o_readdata(m_readdata), .o_readdata_valid(m_readdata_valid),
        .o_rd_count(rd_count), .o_wr_count(wr_count), .o_rd_addr(rd_addr),
        .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_rd_seq(rd_seq), .o_wr_seq(wr_seq)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [LINE_W-1:0] got,
                                input logic [LINE_W-1:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    function automatic logic [WORD_W-1:0] shadow_word(input logic [ADDR_W-1:0] a);
        logic [WORD_W-1:0] word;
        word = {7'b0, a} ^ MEM_PATTERN; // memory contents before any write
        foreach (shadow_addr[i]) begin
            if (shadow_addr[i] == a) begin
                word = shadow_data[i];
            end
        end
        return word;
    endfunction

    function automatic logic [LINE_W-1:0] shadow_line(input logic [LINE_ADDR_W-1:0] la);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*WORD_W +: WORD_W] = shadow_word({la, 2'(w)});
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input int set, input int ofs);
        return {tag, SET_W'(set), OFS_W'(ofs)};
    endfunction

    task automatic wait_idle();
        int n = 0;
        while (p_waitrequest) begin
            n++;
            assert (n < TIMEOUT) else stop_run("timeout waiting for the cache to go idle");
            @(negedge clk);
        end
    endtask

    // one read, checked against the shadow model; cycles counts from the request
    task automatic read_word(input logic [ADDR_W-1:0] a, output int cycles);
        int n;
        wait_idle();
        p_addr = a;
        p_read = 1'b1;
        @(negedge clk);
        p_read = 1'b0;
        n      = 1;
        while (!p_readdata_valid) begin
            n++;
            assert (n < TIMEOUT) else stop_run("timeout waiting for read data");
            @(negedge clk);
        end
        cycles = n;
        expect_equal("o_p_readdata", p_readdata, shadow_word(a));
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] data,
                              input logic [3:0] be);
        logic [WORD_W-1:0] word;
        wait_idle();
        word = shadow_word(a);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow_addr.push_back(a);
        shadow_data.push_back(word);
        p_addr      = a;
        p_writedata = data;
        p_byte_en   = be;
        p_write     = 1'b1;
        @(negedge clk);
        p_write = 1'b0;
        wait_idle();
    endtask

    task automatic reset_outputs_idle();
        expect_equal("o_p_waitrequest", p_waitrequest, 1'b0);
        expect_equal("o_p_readdata_valid", p_readdata_valid, 1'b0);
        expect_equal("o_m_read", m_read, 1'b0);
        expect_equal("o_m_write", m_write, 1'b0);
        expect_equal("o_m_byte_en", m_byte_en, 4'hf);
    endtask

    task automatic read_miss_then_hit();
        logic [ADDR_W-1:0] a;
        int r0;
        int w0;
        int cycles;
        a  = make_addr(TAG_W'($urandom), 1, 2);
        r0 = rd_count;
        w0 = wr_count;
        read_word(a, cycles);
        expect_equal("memory read count", rd_count, r0 + 1);
        expect_equal("o_m_addr of fill", rd_addr, a[ADDR_W-1:OFS_W]);
        read_word(a, cycles);
        expect_equal("read hit latency", cycles, 2);
        expect_equal("memory read count", rd_count, r0 + 1);
        expect_equal("memory write count", wr_count, w0);
    endtask

    task automatic write_hit_merge();
        logic [TAG_W-1:0] tag;
        int r0;
        int w0;
        int cycles;
        tag = TAG_W'($urandom);
        read_word(make_addr(tag, 2, 0), cycles); // bring the line in
        r0 = rd_count;
        w0 = wr_count;
        for (int i = 0; i < 6; i++) begin
            write_word(make_addr(tag, 2, i % 4), $urandom, 4'($urandom_range(1, 15)));
        end
        for (int i = 0; i < 4; i++) begin
            read_word(make_addr(tag, 2, i), cycles);
            expect_equal("read hit latency", cycles, 2);
        end
        expect_equal("memory read count", rd_count, r0);
        expect_equal("memory write count", wr_count, w0);
    endtask

    task automatic write_miss_fill();
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] a;
        int r0;
        int w0;
        int cycles;
        tag = TAG_W'($urandom);
        a   = make_addr(tag, 3, 2);
        r0  = rd_count;
        w0  = wr_count;
        write_word(a, $urandom, 4'b1011);
        expect_equal("memory read count", rd_count, r0 + 1);
        expect_equal("o_m_addr of fill", rd_addr, a[ADDR_W-1:OFS_W]);
        read_word(a, cycles);
        read_word(make_addr(tag, 3, 0), cycles);
        expect_equal("memory read count", rd_count, r0 + 1);
        expect_equal("memory write count", wr_count, w0);
    endtask

    task automatic eviction_order();
        logic [TAG_W-1:0]  base;
        logic [ADDR_W-1:0] a;
        int r0;
        int w0;
        int cycles;
        base = TAG_W'($urandom);
        r0   = rd_count;
        w0   = wr_count;
        for (int i = 0; i < 9; i++) begin
            read_word(make_addr(TAG_W'(base + i), 5, 1), cycles);
        end
        expect_equal("memory read count", rd_count, r0 + 9);
        // only the first tag should have left the set
        for (int i = 1; i < 9; i++) begin
            read_word(make_addr(TAG_W'(base + i), 5, 1), cycles);
        end
        expect_equal("memory read count", rd_count, r0 + 9);
        a = make_addr(base, 5, 1);
        read_word(a, cycles);
        expect_equal("memory read count", rd_count, r0 + 10);
        expect_equal("o_m_addr of fill", rd_addr, a[ADDR_W-1:OFS_W]);
        expect_equal("memory write count", wr_count, w0);
    endtask

    task automatic dirty_writeback();
        logic [TAG_W-1:0]  base;
        logic [ADDR_W-1:0] dirty;
        logic [ADDR_W-1:0] a;
        int r0;
        int w0;
        int cycles;
        base  = TAG_W'($urandom);
        dirty = make_addr(base, 6, 3);
        write_word(dirty, $urandom, 4'b1111); // lands in way 0
        for (int i = 1; i < 8; i++) begin
            read_word(make_addr(TAG_W'(base + i), 6, 0), cycles);
        end
        r0 = rd_count;
        w0 = wr_count;
        a  = make_addr(TAG_W'(base + 8), 6, 0);
        read_word(a, cycles);
        expect_equal("memory write count", wr_count, w0 + 1);
        expect_equal("o_m_addr of write-back", wr_addr, dirty[ADDR_W-1:OFS_W]);
        expect_equal("o_m_writedata", wr_data, shadow_line(dirty[ADDR_W-1:OFS_W]));
        expect_equal("memory read count", rd_count, r0 + 1);
        expect_equal("o_m_addr of fill", rd_addr, a[ADDR_W-1:OFS_W]);
        assert (wr_seq < rd_seq) else stop_run("write-back did not come before the fill read");
        read_word(dirty, cycles); // written-back data returns from memory
        expect_equal("memory read count", rd_count, r0 + 2);
        expect_equal("memory write count", wr_count, w0 + 1);
    endtask

    // a stalled memory command keeps its type, address and data
    always @(negedge clk) begin
        if ((last_m_read || last_m_write) && m_waitrequest) begin
            assert (m_read === last_m_read && m_write === last_m_write
                    && m_addr === last_m_addr && m_writedata === last_m_writedata)
            else stop_run("memory command changed while waitrequest was high");
        end
        last_m_read      = m_read;
        last_m_write     = m_write;
        last_m_addr      = m_addr;
        last_m_writedata = m_writedata;
    end

    initial begin
        void'($urandom(32'hfb1c84dd));
        clk              = 1'b0;
        rst              = 1'b1;
        p_addr           = '0;
        p_read           = 1'b0;
        p_write          = 1'b0;
        p_writedata      = '0;
        p_byte_en        = '0;
        last_m_read      = 1'b0;
        last_m_write     = 1'b0;
        last_m_addr      = '0;
        last_m_writedata = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_outputs_idle();
        read_miss_then_hit();
        write_hit_merge();
        write_miss_fill();
        eviction_order();
        dirty_writeback();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
source/cache_pkg.sv
source/cache_way.sv
source/plru_tree.sv
source/cache_ctrl.sv
source/cache_top.sv
tests/mem_model.sv
tests/tb_cache_top.sv

/* Bender.yml */
package:
  name: sa_dcache

sources:
  - files:
      - source/cache_pkg.sv
      - source/cache_way.sv
      - source/plru_tree.sv
      - source/cache_ctrl.sv
      - source/cache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/tb_cache_top.sv
